//--- src/stbuf_pkg.sv
`default_nettype none

package stbuf_pkg;

   //------------------------------
   // widths
   //------------------------------
   localparam int DATA_W = 32;
   localparam int BYTE_W = DATA_W / 8;   // byte lanes per word

   // store size, as issued by the pipe
   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } size_e;

   // entry data word
   // the drain takes it whole, forwarding picks it apart per lane
   typedef union packed {
      logic [DATA_W-1:0]           word;
      logic [BYTE_W-1:0][7:0]      lanes;
   } stbuf_word_u;

endpackage

`default_nettype wire

//--- src/stbuf_if.sv
`timescale 1ns/1ps
`default_nettype none

// write and resolve side, alloc -> entries and fwd
interface stbuf_wr_if #(
   parameter int DEPTH  = 4,
   parameter int ADDR_W = 16
);
   localparam int PTR_W = $clog2(DEPTH);

   logic                             wr_en;
   logic [PTR_W-1:0]                 wr_ptr;      // also the oldest slot for fwd
   logic [ADDR_W-1:0]                wr_addr;
   logic [stbuf_pkg::BYTE_W-1:0]     wr_byteen;
   stbuf_pkg::stbuf_word_u           wr_data;
   logic                             res_vld;
   logic [PTR_W-1:0]                 res_ptr;
   logic                             res_commit;

   modport alloc (
      output wr_en, wr_ptr, wr_addr, wr_byteen, wr_data,
      output res_vld, res_ptr, res_commit
   );

   modport entries (
      input wr_en, wr_ptr, wr_addr, wr_byteen, wr_data,
      input res_vld, res_ptr, res_commit
   );

   modport fwd (
      input wr_en, wr_ptr, wr_addr, wr_byteen, wr_data
   );
endinterface

// head of queue, entries <-> drain
interface stbuf_head_if #(
   parameter int ADDR_W = 16
);
   logic                             head_drain;
   logic                             head_flush;
   logic [ADDR_W-1:0]                head_addr;
   logic [stbuf_pkg::BYTE_W-1:0]     head_byteen;
   stbuf_pkg::stbuf_word_u           head_data;
   logic                             pop;         // one cycle, advances rd ptr

   modport entries (
      output head_drain, head_flush, head_addr, head_byteen, head_data,
      input  pop
   );

   modport drain (
      input  head_drain, head_flush, head_addr, head_byteen, head_data,
      output pop
   );
endinterface

`default_nettype wire

//--- src/stbuf_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module stbuf_alloc #(
   parameter int DEPTH  = 4,
   parameter int ADDR_W = 16
) (
   input  wire logic                    clk,
   input  wire logic                    rst,
   input  wire logic                    st_vld,
   input  wire logic [ADDR_W-1:0]       st_addr,
   input  wire stbuf_pkg::size_e        st_size,
   input  wire logic [stbuf_pkg::DATA_W-1:0] st_data,
   input  wire logic                    res_vld,
   input  wire logic                    res_commit,
   input  wire logic                    st_full,
   stbuf_wr_if.alloc                    wr
);

   localparam int PTR_W  = $clog2(DEPTH);
   localparam int LANE_W = $clog2(stbuf_pkg::BYTE_W);

   logic                            st_accept;
   logic [stbuf_pkg::BYTE_W-1:0]    size_mask;
   logic [PTR_W-1:0]                wr_ptr;
   logic [PTR_W-1:0]                wr_ptr_d1, wr_ptr_d2;
   logic                            accept_d1, accept_d2;

   assign st_accept = st_vld & ~st_full;   // store while full is dropped

   // byte enables, then shifted to the lane of the low address
   always_comb begin
      case (st_size)
         stbuf_pkg::SZ_BYTE: size_mask = stbuf_pkg::BYTE_W'(1);
         stbuf_pkg::SZ_HALF: size_mask = stbuf_pkg::BYTE_W'(3);
         default:            size_mask = '1;
      endcase
   end

   assign wr.wr_en      = st_accept;
   assign wr.wr_ptr     = wr_ptr;
   assign wr.wr_addr    = st_addr;
   assign wr.wr_byteen  = size_mask << st_addr[LANE_W-1:0];
   assign wr.wr_data.word = st_data;

   //------------------------------
   // write pointer and staging
   //------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr    <= '0;
         accept_d1 <= 1'b0;
         accept_d2 <= 1'b0;
      end else begin
         if (st_accept)
            wr_ptr <= wr_ptr + 1'b1;
         accept_d1 <= st_accept;
         accept_d2 <= accept_d1;
      end
   end

   // pointer of the store two cycles back, tags the resolve
   always_ff @(posedge clk) begin
      wr_ptr_d1 <= wr_ptr;
      wr_ptr_d2 <= wr_ptr_d1;
   end

   assign wr.res_vld    = res_vld & accept_d2;   // no entry, nothing to resolve
   assign wr.res_ptr    = wr_ptr_d2;
   assign wr.res_commit = res_commit;

endmodule

`default_nettype wire

//--- src/stbuf_entries.sv
`timescale 1ns/1ps
`default_nettype none

module stbuf_entries #(
   parameter int DEPTH  = 4,
   parameter int ADDR_W = 16
) (
   input  wire logic                                  clk,
   input  wire logic                                  rst,
   stbuf_wr_if.entries                                wr,
   stbuf_head_if.entries                              head,
   output logic [DEPTH-1:0]                           ent_vld,
   output logic [DEPTH-1:0]                           ent_flush,
   output logic [DEPTH-1:0][ADDR_W-1:0]               ent_addr,
   output logic [DEPTH-1:0][stbuf_pkg::BYTE_W-1:0]    ent_byteen,
   output stbuf_pkg::stbuf_word_u [DEPTH-1:0]         ent_data,
   output logic                                       st_full,
   output logic                                       st_empty
);

   localparam int PTR_W = $clog2(DEPTH);

   logic [DEPTH-1:0]   ent_drain;
   logic [PTR_W-1:0]   rd_ptr;

   //------------------------------
   // status bits and read pointer
   //------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         ent_vld   <= '0;
         ent_drain <= '0;
         ent_flush <= '0;
         rd_ptr    <= '0;
      end else begin
         for (int i = 0; i < DEPTH; i++) begin
            if (wr.wr_en && wr.wr_ptr == PTR_W'(i))
               ent_vld[i] <= 1'b1;
            if (wr.res_vld && wr.res_ptr == PTR_W'(i)) begin
               ent_drain[i] <= wr.res_commit;
               ent_flush[i] <= ~wr.res_commit;
            end
            // pop wins, head is already resolved by then
            if (head.pop && rd_ptr == PTR_W'(i)) begin
               ent_vld[i]   <= 1'b0;
               ent_drain[i] <= 1'b0;
               ent_flush[i] <= 1'b0;
            end
         end
         if (head.pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // entry payload
   always_ff @(posedge clk) begin
      if (wr.wr_en) begin
         ent_addr[wr.wr_ptr]   <= wr.wr_addr;
         ent_byteen[wr.wr_ptr] <= wr.wr_byteen;
         ent_data[wr.wr_ptr]   <= wr.wr_data;
      end
   end

   // head of queue
   assign head.head_drain  = ent_drain[rd_ptr];
   assign head.head_flush  = ent_flush[rd_ptr];
   assign head.head_addr   = ent_addr[rd_ptr];
   assign head.head_byteen = ent_byteen[rd_ptr];
   assign head.head_data   = ent_data[rd_ptr];

   assign st_full  = &ent_vld;    // every slot taken
   assign st_empty = ~|ent_vld;

endmodule

`default_nettype wire

//--- src/stbuf_fwd.sv
`timescale 1ns/1ps
`default_nettype none

module stbuf_fwd #(
   parameter int DEPTH  = 4,
   parameter int ADDR_W = 16
) (
   input  wire logic                                  clk,
   input  wire logic                                  rst,
   input  wire logic                                  ld_vld,
   input  wire logic [ADDR_W-1:0]                     ld_addr,
   stbuf_wr_if.fwd                                    wr,
   input  wire logic [DEPTH-1:0]                      ent_vld,
   input  wire logic [DEPTH-1:0]                      ent_flush,
   input  wire logic [DEPTH-1:0][ADDR_W-1:0]          ent_addr,
   input  wire logic [DEPTH-1:0][stbuf_pkg::BYTE_W-1:0] ent_byteen,
   input  wire stbuf_pkg::stbuf_word_u [DEPTH-1:0]    ent_data,
   output logic [stbuf_pkg::BYTE_W-1:0]               fwd_byteen,
   output logic [stbuf_pkg::DATA_W-1:0]               fwd_data
);

   localparam int PTR_W  = $clog2(DEPTH);
   localparam int LANE_W = $clog2(stbuf_pkg::BYTE_W);

   logic [DEPTH-1:0]                  ent_hit;
   logic                              wr_hit;
   logic [PTR_W-1:0]                  idx;
   logic [stbuf_pkg::BYTE_W-1:0]      byteen_c;
   stbuf_pkg::stbuf_word_u            data_c;

   // word compare, flushed entries never forward
   always_comb begin
      for (int i = 0; i < DEPTH; i++)
         ent_hit[i] = ent_vld[i] & ~ent_flush[i] &
                      (ent_addr[i][ADDR_W-1:LANE_W] == ld_addr[ADDR_W-1:LANE_W]);
   end

   assign wr_hit = wr.wr_en & (wr.wr_addr[ADDR_W-1:LANE_W] == ld_addr[ADDR_W-1:LANE_W]);

   //------------------------------
   // merge, oldest first
   //------------------------------
   always_comb begin
      byteen_c = '0;
      data_c   = '0;
      idx      = wr.wr_ptr;
      for (int k = 0; k < DEPTH; k++) begin
         idx = wr.wr_ptr + PTR_W'(k);   // slot at wr_ptr is the oldest
         for (int j = 0; j < stbuf_pkg::BYTE_W; j++) begin
            if (ent_hit[idx] && ent_byteen[idx][j]) begin
               byteen_c[j]     = 1'b1;
               data_c.lanes[j] = ent_data[idx].lanes[j];
            end
         end
      end
      // store in flight this cycle is younger than any entry
      for (int j = 0; j < stbuf_pkg::BYTE_W; j++) begin
         if (wr_hit && wr.wr_byteen[j]) begin
            byteen_c[j]     = 1'b1;
            data_c.lanes[j] = wr.wr_data.lanes[j];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst)
         fwd_byteen <= '0;
      else
         fwd_byteen <= ld_vld ? byteen_c : '0;
   end

   always_ff @(posedge clk)
      fwd_data <= ld_vld ? data_c.word : '0;   // zero when no load

endmodule

`default_nettype wire

//--- src/stbuf_drain_wb.sv
`timescale 1ns/1ps
`default_nettype none

module stbuf_drain_wb #(
   parameter int ADDR_W = 16
) (
   input  wire logic                         clk,
   input  wire logic                         rst,
   stbuf_head_if.drain                       head,
   output logic                              wb_cyc,
   output logic                              wb_stb,
   output logic                              wb_we,
   output logic [ADDR_W-1:0]                 wb_adr,
   output logic [stbuf_pkg::BYTE_W-1:0]      wb_sel,
   output logic [stbuf_pkg::DATA_W-1:0]      wb_dat_o,
   input  wire logic                         wb_ack
);

   localparam int LANE_W = $clog2(stbuf_pkg::BYTE_W);

   logic busy;   // bus cycle open

   // idle: flushed head goes at once, busy: pop on ack
   assign head.pop = busy ? wb_ack : head.head_flush;

   always_ff @(posedge clk) begin
      if (rst)
         busy <= 1'b0;
      else if (busy)
         busy <= ~wb_ack;            // one idle cycle after each ack
      else
         busy <= head.head_drain;
   end

   // launch registers, held while the head stays put
   always_ff @(posedge clk) begin
      if (!busy && head.head_drain) begin
         wb_adr   <= {head.head_addr[ADDR_W-1:LANE_W], LANE_W'(0)};
         wb_sel   <= head.head_byteen;
         wb_dat_o <= head.head_data.word;
      end
   end

   assign wb_cyc = busy;
   assign wb_stb = busy;
   assign wb_we  = busy;   // writes only

endmodule

`default_nettype wire

//--- src/stbuf_top.sv
`timescale 1ns/1ps
`default_nettype none

module stbuf_top #(
   parameter int DEPTH  = 4,
   parameter int ADDR_W = 16
) (
   input  wire logic                         clk,
   input  wire logic                         rst,
   // store request
   input  wire logic                         st_vld,
   input  wire logic [ADDR_W-1:0]            st_addr,
   input  wire stbuf_pkg::size_e             st_size,
   input  wire logic [stbuf_pkg::DATA_W-1:0] st_data,
   // resolve, two cycles after the store
   input  wire logic                         res_vld,
   input  wire logic                         res_commit,
   // load forwarding
   input  wire logic                         ld_vld,
   input  wire logic [ADDR_W-1:0]            ld_addr,
   output logic [stbuf_pkg::BYTE_W-1:0]      fwd_byteen,
   output logic [stbuf_pkg::DATA_W-1:0]      fwd_data,
   output logic                              st_full,
   output logic                              st_empty,
   // wishbone master
   output logic                              wb_cyc,
   output logic                              wb_stb,
   output logic                              wb_we,
   output logic [ADDR_W-1:0]                 wb_adr,
   output logic [stbuf_pkg::BYTE_W-1:0]      wb_sel,
   output logic [stbuf_pkg::DATA_W-1:0]      wb_dat_o,
   input  wire logic                         wb_ack
);

   logic [DEPTH-1:0]                          ent_vld;
   logic [DEPTH-1:0]                          ent_flush;
   logic [DEPTH-1:0][ADDR_W-1:0]              ent_addr;
   logic [DEPTH-1:0][stbuf_pkg::BYTE_W-1:0]   ent_byteen;
   stbuf_pkg::stbuf_word_u [DEPTH-1:0]        ent_data;

   stbuf_wr_if   #(.DEPTH(DEPTH), .ADDR_W(ADDR_W)) wr_bus ();
   stbuf_head_if #(.ADDR_W(ADDR_W))                head_bus ();

   stbuf_alloc #(.DEPTH(DEPTH), .ADDR_W(ADDR_W)) alloc_i (
      .clk, .rst, .st_vld, .st_addr, .st_size, .st_data,
      .res_vld, .res_commit, .st_full,
      .wr (wr_bus)
   );

   stbuf_entries #(.DEPTH(DEPTH), .ADDR_W(ADDR_W)) entries_i (
      .clk, .rst,
      .wr (wr_bus), .head (head_bus),
      .ent_vld, .ent_flush, .ent_addr, .ent_byteen, .ent_data,
      .st_full, .st_empty
   );

   stbuf_fwd #(.DEPTH(DEPTH), .ADDR_W(ADDR_W)) fwd_i (
      .clk, .rst, .ld_vld, .ld_addr,
      .wr (wr_bus),
      .ent_vld, .ent_flush, .ent_addr, .ent_byteen, .ent_data,
      .fwd_byteen, .fwd_data
   );

   stbuf_drain_wb #(.ADDR_W(ADDR_W)) drain_i (
      .clk, .rst,
      .head (head_bus),
      .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_dat_o, .wb_ack
   );

endmodule

`default_nettype wire

//--- sim/stbuf_checker.sv
`timescale 1ns/1ps
`default_nettype none

module stbuf_checker #(
   parameter int ADDR_W = 16
) (
   input  wire logic                         clk,
   input  wire logic                         rst,
   input  wire logic                         st_vld,
   input  wire logic                         st_full,
   input  wire logic                         st_empty,
   input  wire logic                         wb_cyc,
   input  wire logic                         wb_stb,
   input  wire logic                         wb_we,
   input  wire logic [ADDR_W-1:0]            wb_adr,
   input  wire logic [stbuf_pkg::BYTE_W-1:0] wb_sel,
   input  wire logic [stbuf_pkg::DATA_W-1:0] wb_dat_o,
   input  wire logic                         wb_ack
);

   int fail_count = 0;   // assertion failures so far

   no_store_when_full: assert property (@(posedge clk) disable iff (rst)
      st_vld |-> !st_full)
      else begin
         $error("store issued while st_full is high");
         fail_count = fail_count + 1;
      end

   cyc_stb_paired: assert property (@(posedge clk) disable iff (rst)
      wb_cyc == wb_stb)
      else begin
         $error("wb_cyc and wb_stb differ");
         fail_count = fail_count + 1;
      end

   // request held until the slave acks
   bus_held: assert property (@(posedge clk) disable iff (rst)
      (wb_cyc && !wb_ack) |=> (wb_cyc && $stable(wb_adr) && $stable(wb_sel) &&
                               $stable(wb_dat_o) && $stable(wb_we)))
      else begin
         $error("bus signals changed before wb_ack");
         fail_count = fail_count + 1;
      end

   flags_exclusive: assert property (@(posedge clk) disable iff (rst)
      !(st_empty && st_full))
      else begin
         $error("st_empty and st_full both high");
         fail_count = fail_count + 1;
      end

endmodule

bind stbuf_top stbuf_checker #(.ADDR_W(ADDR_W)) checker_i (
   .clk, .rst, .st_vld, .st_full, .st_empty,
   .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_dat_o, .wb_ack
);

`default_nettype wire

//--- sim/stbuf_tb.sv
`timescale 1ns/1ps
`default_nettype none

module stbuf_tb;

   localparam int DEPTH     = 4;
   localparam int ADDR_W    = 16;
   localparam int MAX_LINES = 64;
   localparam int FIELDS    = 6;   // op addr size data flag expect

   logic                            clk = 1'b0;
   logic                            rst;
   logic                            st_vld;
   logic [ADDR_W-1:0]               st_addr;
   stbuf_pkg::size_e                st_size;
   logic [stbuf_pkg::DATA_W-1:0]    st_data;
   logic                            st_commit_q;   // commit flag riding with the store
   logic                            res_pend;
   logic                            res_pend_commit;
   logic                            res_vld = 1'b0;
   logic                            res_commit = 1'b0;
   logic                            ld_vld;
   logic [ADDR_W-1:0]               ld_addr;
   logic [stbuf_pkg::BYTE_W-1:0]    fwd_byteen;
   logic [stbuf_pkg::DATA_W-1:0]    fwd_data;
   logic                            st_full;
   logic                            st_empty;
   logic                            wb_cyc;
   logic                            wb_stb;
   logic                            wb_we;
   logic [ADDR_W-1:0]               wb_adr;
   logic [stbuf_pkg::BYTE_W-1:0]    wb_sel;
   logic [stbuf_pkg::DATA_W-1:0]    wb_dat_o;
   logic                            wb_ack = 1'b0;

   logic [31:0]                     pat [0:MAX_LINES*FIELDS-1];
   int                              n_lines;
   int                              cycle_count = 0;
   int                              cycle_limit = 0;
   int                              tests_run = 0;
   int                              tests_failed = 0;

   // memory slave state
   logic [31:0]                     lfsr = 32'h7c88;
   logic [1:0]                      delay;
   logic                            in_req;
   int                              ack_wait;
   int                              stall;
   int                              stall_q [$];   // extra wait per committed store
   logic [ADDR_W-1:0]               log_adr [$];
   logic [stbuf_pkg::BYTE_W-1:0]    log_sel [$];
   logic [stbuf_pkg::DATA_W-1:0]    log_dat [$];
   logic                            log_we [$];

   stbuf_top #(.DEPTH(DEPTH), .ADDR_W(ADDR_W)) stbuf_top_i (
      .clk, .rst, .st_vld, .st_addr, .st_size, .st_data,
      .res_vld, .res_commit, .ld_vld, .ld_addr,
      .fwd_byteen, .fwd_data, .st_full, .st_empty,
      .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_dat_o, .wb_ack
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   function automatic logic [31:0] lane_mask(input logic [3:0] be);
      logic [31:0] m;
      for (int j = 0; j < 4; j++)
         m[8*j +: 8] = {8{be[j]}};
      return m;
   endfunction

   //------------------------------
   // resolve, two cycles after each store
   //------------------------------
   always @(posedge clk) begin
      if (rst) begin
         res_pend        <= 1'b0;
         res_pend_commit <= 1'b0;
         res_vld         <= 1'b0;
         res_commit      <= 1'b0;
      end else begin
         res_pend        <= st_vld;
         res_pend_commit <= st_commit_q;
         res_vld         <= res_pend;
         res_commit      <= res_pend_commit;
      end
   end

   //------------------------------
   // wishbone memory slave
   //------------------------------
   always @(posedge clk) begin
      if (rst) begin
         wb_ack <= 1'b0;
         in_req = 1'b0;
         ack_wait = 0;
      end else begin
         wb_ack <= 1'b0;
         if (wb_cyc && wb_stb && !wb_ack) begin
            if (!in_req) begin
               in_req = 1'b1;
               for (int b = 0; b < 2; b++) begin
                  lfsr = lfsr_next(lfsr);
                  delay = {delay[0], lfsr[0]};
               end
               stall = 0;
               if (stall_q.size() > 0)
                  stall = stall_q.pop_front();
               ack_wait = int'(delay) + stall;
            end
            if (ack_wait == 0) begin
               wb_ack <= 1'b1;
               in_req = 1'b0;
               log_adr.push_back(wb_adr);
               log_sel.push_back(wb_sel);
               log_dat.push_back(wb_dat_o);
               log_we.push_back(wb_we);
            end else begin
               ack_wait = ack_wait - 1;
            end
         end
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("Simulation failed");
         $finish;
      end
   end

   //------------------------------
   // drivers
   //------------------------------
   task automatic drive_idle();
      @(posedge clk);
      st_vld <= 1'b0;
      ld_vld <= 1'b0;
   endtask

   task automatic release_reset();
      @(posedge clk);
      rst <= 1'b0;
   endtask

   task automatic finish_test(input string name, input bit ok);
      tests_run++;
      if (!ok)
         tests_failed++;
      $display("%-12s %s", name, ok ? "ok" : "FAILED");
   endtask

   // idle state right after reset
   task automatic check_reset_state();
      bit ok;
      ok = 1'b1;
      @(negedge clk);
      if (st_empty !== 1'b1) begin
         $display("[ERROR] reset st_empty expected 1 actual %b", st_empty);
         ok = 1'b0;
      end
      if (st_full !== 1'b0) begin
         $display("[ERROR] reset st_full expected 0 actual %b", st_full);
         ok = 1'b0;
      end
      if ({wb_cyc, wb_stb} !== 2'b00) begin
         $display("[ERROR] reset wb_cyc/wb_stb expected 00 actual %b%b", wb_cyc, wb_stb);
         ok = 1'b0;
      end
      if (fwd_byteen !== '0) begin
         $display("[ERROR] reset fwd_byteen expected 0 actual %h", fwd_byteen);
         ok = 1'b0;
      end
      finish_test("reset", ok);
   endtask

   task automatic do_store(input logic [31:0] addr, input logic [31:0] size,
                           input logic [31:0] data, input logic [31:0] commit,
                           input logic [31:0] extra);
      drive_idle();
      @(negedge clk);
      while (st_full)   // no store into a full buffer
         @(negedge clk);
      @(posedge clk);
      st_vld      <= 1'b1;
      st_addr     <= addr[ADDR_W-1:0];
      st_size     <= stbuf_pkg::size_e'(size[1:0]);
      st_data     <= data;
      st_commit_q <= commit[0];
      if (commit[0])
         stall_q.push_back(int'(extra));
   endtask

   task automatic check_load(input int n, input logic [31:0] addr, input logic [31:0] exp_be,
                             input logic [31:0] same_cycle, input logic [31:0] exp_data);
      string       name;
      logic [31:0] mask;
      bit          ok;
      name = $sformatf("load_%0d", n);
      ok   = 1'b1;
      if (!same_cycle[0])
         drive_idle();
      ld_vld  <= 1'b1;
      ld_addr <= addr[ADDR_W-1:0];
      drive_idle();
      @(negedge clk);   // result one cycle after the load
      if (fwd_byteen !== exp_be[3:0]) begin
         $display("[ERROR] %s byteen expected %h actual %h", name, exp_be[3:0], fwd_byteen);
         ok = 1'b0;
      end
      mask = lane_mask(exp_be[3:0]);
      if ((fwd_data & mask) !== (exp_data & mask)) begin
         $display("[ERROR] %s data expected %h actual %h", name, exp_data & mask,
                  fwd_data & mask);
         ok = 1'b0;
      end
      finish_test(name, ok);
   endtask

   // drain done, so no bus cycle may be open
   task automatic wait_empty(input int n);
      string name;
      bit    ok;
      name = $sformatf("empty_%0d", n);
      ok   = 1'b1;
      drive_idle();
      @(negedge clk);
      while (!st_empty)
         @(negedge clk);
      if ({wb_cyc, wb_stb} !== 2'b00) begin
         $display("[ERROR] %s wb_cyc/wb_stb expected 00 actual %b%b", name, wb_cyc, wb_stb);
         ok = 1'b0;
      end
      finish_test(name, ok);
   endtask

   task automatic check_write(input int n, input logic [31:0] adr, input logic [31:0] sel,
                              input logic [31:0] data);
      string                        name;
      bit                           ok;
      logic [ADDR_W-1:0]            got_adr;
      logic [stbuf_pkg::BYTE_W-1:0] got_sel;
      logic [31:0]                  got_dat;
      logic                         got_we;
      name = $sformatf("write_%0d", n);
      ok   = 1'b1;
      if (log_adr.size() == 0) begin
         $display("%s: no bus write was seen where one was expected", name);
         ok = 1'b0;
      end else begin
         got_adr = log_adr.pop_front();
         got_sel = log_sel.pop_front();
         got_dat = log_dat.pop_front();
         got_we  = log_we.pop_front();
         if (got_adr !== adr[ADDR_W-1:0]) begin
            $display("[ERROR] %s adr expected %h actual %h", name, adr[ADDR_W-1:0], got_adr);
            ok = 1'b0;
         end
         if (got_sel !== sel[3:0]) begin
            $display("[ERROR] %s sel expected %h actual %h", name, sel[3:0], got_sel);
            ok = 1'b0;
         end
         if (got_dat !== data) begin
            $display("[ERROR] %s data expected %h actual %h", name, data, got_dat);
            ok = 1'b0;
         end
         if (got_we !== 1'b1) begin
            $display("[ERROR] %s we expected 1 actual %b", name, got_we);
            ok = 1'b0;
         end
      end
      finish_test(name, ok);
   endtask

   task automatic check_full(input int n, input logic [31:0] exp_full);
      bit ok;
      ok = 1'b1;
      drive_idle();
      @(negedge clk);
      if (st_full !== exp_full[0]) begin
         $display("[ERROR] full_%0d st_full expected %b actual %b", n, exp_full[0], st_full);
         ok = 1'b0;
      end
      finish_test($sformatf("full_%0d", n), ok);
   endtask

   task automatic run_line(input int n);
      logic [31:0] op;
      logic [31:0] f1;
      logic [31:0] f2;
      logic [31:0] f3;
      logic [31:0] f4;
      logic [31:0] f5;
      op = pat[n*FIELDS];
      f1 = pat[n*FIELDS+1];
      f2 = pat[n*FIELDS+2];
      f3 = pat[n*FIELDS+3];
      f4 = pat[n*FIELDS+4];
      f5 = pat[n*FIELDS+5];
      case (op)
         32'd1:   do_store(f1, f2, f3, f4, f5);
         32'd2:   check_load(n, f1, f2, f4, f5);
         32'd3:   wait_empty(n);
         32'd4:   check_write(n, f1, f2, f3);
         32'd5:   check_full(n, f5);
         default: begin
            $display("line %0d: unknown opcode %0h in the pattern file", n, op);
            tests_failed++;
         end
      endcase
   endtask

   //------------------------------
   // main sequence
   //------------------------------
   initial begin
      rst         = 1'b1;
      st_vld      = 1'b0;
      st_addr     = '0;
      st_size     = stbuf_pkg::SZ_BYTE;
      st_data     = '0;
      st_commit_q = 1'b0;
      ld_vld      = 1'b0;
      ld_addr     = '0;
      for (int i = 0; i < MAX_LINES*FIELDS; i++)
         pat[i] = '0;
      $readmemh("sim/stbuf_patterns.mem", pat);
      n_lines = 0;
      while (n_lines < MAX_LINES && pat[n_lines*FIELDS] != 0)
         n_lines++;
      cycle_limit = 40 * (n_lines + 1);   // terminator line counts too
      repeat (2) @(posedge clk);
      release_reset();
      check_reset_state();
      for (int n = 0; n < n_lines; n++)
         run_line(n);
      drive_idle();
      @(negedge clk);
      if (log_adr.size() != 0) begin
         $display("bus_idle: %0d bus writes appeared that no pattern expected",
                  log_adr.size());
         finish_test("bus_idle", 1'b0);
      end else begin
         finish_test("bus_idle", 1'b1);
      end
      if (stbuf_top_i.checker_i.fail_count != 0) begin
         $display("checker: %0d assertion failures", stbuf_top_i.checker_i.fail_count);
         tests_failed++;
      end
      $display("tests run %0d, failed %0d", tests_run, tests_failed);
      if (tests_failed == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/stbuf_patterns.mem
// op: 1 store, 2 load check, 3 wait empty, 4 expect write, 5 expect full, 0 end (all hex)
// op addr size|byteen|sel data commit|same_cycle ack_stall|expect
1 0100 2 11223344 1 0
1 0105 0 0000aa00 1 0
3 0000 0 00000000 0 0
4 0100 f 11223344 0 0
4 0104 2 0000aa00 0 0
1 0200 2 deadbeef 0 0
1 0204 2 cafef00d 1 0
3 0000 0 00000000 0 0
4 0204 f cafef00d 0 0
1 0300 2 a1a2a3a4 1 14
1 0302 1 b1b20000 1 0
1 0301 0 0000c300 1 0
2 0300 f 00000000 0 b1b2c3a4
2 0700 0 00000000 0 00000000
1 0400 2 55667788 1 0
2 0400 f 00000000 1 55667788
5 0000 0 00000000 0 1
3 0000 0 00000000 0 0
4 0300 f a1a2a3a4 0 0
4 0300 c b1b20000 0 0
4 0300 2 0000c300 0 0
4 0400 f 55667788 0 0
0 0000 0 00000000 0 0

//--- project.f
src/stbuf_pkg.sv
src/stbuf_if.sv
src/stbuf_alloc.sv
src/stbuf_entries.sv
src/stbuf_fwd.sv
src/stbuf_drain_wb.sv
src/stbuf_top.sv
sim/stbuf_checker.sv
sim/stbuf_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/Vstbuf_tb: project.f $(wildcard src/*.sv) $(wildcard sim/*.sv) sim/stbuf_patterns.mem
	verilator --binary --timing --assert -f project.f --top-module stbuf_tb

run: obj_dir/Vstbuf_tb
	./obj_dir/Vstbuf_tb +verilator+error+limit+100 > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG)

lint:
	verilator --lint-only -Wall --timing --assert -f project.f --top-module stbuf_tb

clean:
	rm -rf obj_dir $(LOG)
